// File: source/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data path width of the core.
`define RV_XLEN 32

// Word address width of the instruction and data memories.
`define RV_ADDR_W 10

// Number of architectural registers.
`define RV_REG_COUNT 32

`endif

// File: source/rv_core_pkg.sv
`default_nettype none

`include "rv_core_cfg.svh"

package rv_core_pkg;

    typedef enum logic [6:0] {
        op_rtype  = 7'b0110011,
        op_itype  = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_slt    = 3'd5,
        alu_pass_b = 3'd6
    } alu_op_e;

    // All zero is a bubble.
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    mem_to_reg;
        logic    branch;
        logic    branch_ne;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                  ctrl;
        logic [`RV_ADDR_W+1:0]  pc;
        logic [`RV_XLEN-1:0]    rs1_data;
        logic [`RV_XLEN-1:0]    rs2_data;
        logic [`RV_XLEN-1:0]    imm;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [4:0]             rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t               ctrl;
        logic [`RV_XLEN-1:0] alu_result;
        logic [`RV_XLEN-1:0] store_data;
        logic [4:0]          rd;
    } ex_mem_t;

    typedef struct packed {
        logic                reg_write;
        logic                mem_to_reg;
        logic [`RV_XLEN-1:0] alu_result;
        logic [`RV_XLEN-1:0] load_data;
        logic [4:0]          rd;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: source/decode_control.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module decode_control import rv_core_pkg::*; (
    input  wire logic [`RV_XLEN-1:0] instr,
    output ctrl_t                    ctrl,
    output logic [`RV_XLEN-1:0]      imm
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;

    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30]; // Selects SUB over ADD.

    always_comb begin
        ctrl = '0;
        case (opcode)
            op_rtype: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7_b5 ? alu_sub : alu_add;
                    3'b111:  ctrl.alu_op = alu_and;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b010:  ctrl.alu_op = alu_slt;
                    default: ctrl = '0; // Unsupported funct3 becomes a bubble.
                endcase
            end
            op_itype: begin
                if (funct3 == 3'b000) begin
                    ctrl.reg_write   = 1'b1;
                    ctrl.alu_src_imm = 1'b1;
                    ctrl.alu_op      = alu_add;
                end
            end
            op_lui: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_pass_b;
            end
            op_load: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_add;
            end
            op_store: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_add;
            end
            op_branch: begin
                if (funct3[2:1] == 2'b00) begin
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = funct3[0];
                    ctrl.alu_op    = alu_sub; // Equality comes from the zero flag.
                end
            end
            default: ctrl = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            op_lui:    imm = {instr[31:12], 12'b0};
            op_store:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            default:   imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module register_file (
    input  wire logic                CLK,
    input  wire logic                RESET_N,
    input  wire logic [4:0]          rs1,
    input  wire logic [4:0]          rs2,
    input  wire logic [4:0]          rd,
    input  wire logic [`RV_XLEN-1:0] write_data,
    input  wire logic                write_enable,
    output logic [`RV_XLEN-1:0]      rs1_data,
    output logic [`RV_XLEN-1:0]      rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
    logic                do_write;

    assign do_write = write_enable && (rd != 5'd0);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (do_write) begin
            regs[rd] <= write_data;
        end
    end

    // A write in the same cycle is visible to decode at once.
    assign rs1_data = (rs1 == 5'd0) ? '0 : (do_write && rd == rs1) ? write_data : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : (do_write && rd == rs2) ? write_data : regs[rs2];

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module alu import rv_core_pkg::*; (
    input  alu_op_e                  op,
    input  wire logic [`RV_XLEN-1:0] a,
    input  wire logic [`RV_XLEN-1:0] b,
    output logic [`RV_XLEN-1:0]      result,
    output logic                     zero
);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_slt:    result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_pass_b: result = b; // LUI passes the upper immediate.
            default:    result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
    input  wire logic [4:0] id_rs1,
    input  wire logic [4:0] id_rs2,
    input  wire logic       ex_mem_read,
    input  wire logic [4:0] ex_rd,
    input  wire logic [4:0] ex_rs1,
    input  wire logic [4:0] ex_rs2,
    input  wire logic       mem_reg_write,
    input  wire logic [4:0] mem_rd,
    input  wire logic       wb_reg_write,
    input  wire logic [4:0] wb_rd,
    input  wire logic       branch_taken,
    output logic            stall,
    output logic            flush,
    output logic [1:0]      forward_a,
    output logic [1:0]      forward_b
);

    // The memory stage holds the younger result, so it wins over writeback.
    function automatic logic [1:0] forward_sel(input logic [4:0] rs);
        logic [1:0] sel;
        sel = 2'd0;
        if (rs != 5'd0) begin
            if (mem_reg_write && mem_rd == rs) begin
                sel = 2'd1;
            end else if (wb_reg_write && wb_rd == rs) begin
                sel = 2'd2;
            end
        end
        return sel;
    endfunction

    assign forward_a = forward_sel(ex_rs1);
    assign forward_b = forward_sel(ex_rs2);

    assign stall = ex_mem_read && (ex_rd != 5'd0) &&
                   ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    assign flush = branch_taken;

endmodule

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module rv_core import rv_core_pkg::*; (
    input  wire logic                  CLK,
    input  wire logic                  RESET_N,
    input  wire logic [`RV_XLEN-1:0]   idata,
    input  wire logic [`RV_XLEN-1:0]   ddata_r,
    output logic [`RV_ADDR_W-1:0]      iaddr,
    output logic [`RV_ADDR_W-1:0]      daddr,
    output logic [`RV_XLEN-1:0]        ddata_w,
    output logic                       mem_write,
    output logic                       mem_read,
    output logic                       reg_write_enable,
    output logic [4:0]                 write_register,
    output logic [`RV_XLEN-1:0]        reg_write_data
);

    localparam int PC_W = `RV_ADDR_W + 2;

    logic [PC_W-1:0]     pc;
    logic [PC_W-1:0]     pc_plus4;
    logic [PC_W-1:0]     branch_target;
    logic [PC_W-1:0]     if_id_pc;
    logic [`RV_XLEN-1:0] if_id_instr;
    id_ex_t              id_ex;
    ex_mem_t             ex_mem;
    mem_wb_t             mem_wb;

    ctrl_t               dec_ctrl;
    logic [`RV_XLEN-1:0] dec_imm;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;

    logic                stall;
    logic                flush;
    logic [1:0]          forward_a;
    logic [1:0]          forward_b;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] fwd_b;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                alu_zero;
    logic                branch_taken;
    logic [`RV_XLEN-1:0] wb_data;

    // Fetch.
    assign iaddr         = pc[PC_W-1:2];
    assign pc_plus4      = pc + PC_W'(4);
    assign branch_target = id_ex.pc + id_ex.imm[PC_W-1:0];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc_plus4;
        end
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            if_id_pc    <= '0;
            if_id_instr <= '0; // Opcode zero decodes as a bubble.
        end else if (flush) begin
            if_id_pc    <= '0;
            if_id_instr <= '0;
        end else if (!stall) begin
            if_id_pc    <= pc;
            if_id_instr <= idata;
        end
    end

    // Decode.
    decode_control u_decode_control (
        .instr (if_id_instr),
        .ctrl  (dec_ctrl),
        .imm   (dec_imm)
    );

    register_file u_register_file (
        .CLK          (CLK),
        .RESET_N      (RESET_N),
        .rs1          (if_id_instr[19:15]),
        .rs2          (if_id_instr[24:20]),
        .rd           (mem_wb.rd),
        .write_data   (wb_data),
        .write_enable (mem_wb.reg_write),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    hazard_unit u_hazard_unit (
        .id_rs1        (if_id_instr[19:15]),
        .id_rs2        (if_id_instr[24:20]),
        .ex_mem_read   (id_ex.ctrl.mem_read),
        .ex_rd         (id_ex.rd),
        .ex_rs1        (id_ex.rs1),
        .ex_rs2        (id_ex.rs2),
        .mem_reg_write (ex_mem.ctrl.reg_write),
        .mem_rd        (ex_mem.rd),
        .wb_reg_write  (mem_wb.reg_write),
        .wb_rd         (mem_wb.rd),
        .branch_taken  (branch_taken),
        .stall         (stall),
        .flush         (flush),
        .forward_a     (forward_a),
        .forward_b     (forward_b)
    );

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl     <= (stall || flush) ? ctrl_t'('0) : dec_ctrl;
            id_ex.pc       <= if_id_pc;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= dec_imm;
            id_ex.rs1      <= if_id_instr[19:15];
            id_ex.rs2      <= if_id_instr[24:20];
            id_ex.rd       <= if_id_instr[11:7];
        end
    end

    // Execute.
    function automatic logic [`RV_XLEN-1:0] fwd_mux(input logic [1:0]          sel,
                                                   input logic [`RV_XLEN-1:0] reg_val);
        logic [`RV_XLEN-1:0] val;
        case (sel)
            2'd1:    val = ex_mem.alu_result;
            2'd2:    val = wb_data;
            default: val = reg_val;
        endcase
        return val;
    endfunction

    assign op_a  = fwd_mux(forward_a, id_ex.rs1_data);
    assign fwd_b = fwd_mux(forward_b, id_ex.rs2_data);
    assign op_b  = id_ex.ctrl.alu_src_imm ? id_ex.imm : fwd_b;

    alu u_alu (
        .op     (id_ex.ctrl.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // BEQ takes on zero, BNE on nonzero.
    assign branch_taken = id_ex.ctrl.branch && (alu_zero ^ id_ex.ctrl.branch_ne);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= fwd_b;
            ex_mem.rd         <= id_ex.rd;
        end
    end

    // Memory.
    assign daddr     = ex_mem.alu_result[PC_W-1:2];
    assign ddata_w   = ex_mem.store_data;
    assign mem_write = ex_mem.ctrl.mem_write;
    assign mem_read  = ex_mem.ctrl.mem_read;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            mem_wb <= '0;
        end else begin
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.load_data  <= ddata_r;
            mem_wb.rd         <= ex_mem.rd;
        end
    end

    // Writeback.
    assign wb_data          = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;
    assign reg_write_enable = mem_wb.reg_write;
    assign write_register   = mem_wb.rd;
    assign reg_write_data   = wb_data;

endmodule

`default_nettype wire

// File: verif/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_cfg.svh"

module tb_rv_core;

    localparam int mem_words = 1 << `RV_ADDR_W;

    logic                  CLK;
    logic                  RESET_N;
    logic [`RV_XLEN-1:0]   idata;
    logic [`RV_XLEN-1:0]   ddata_r;
    logic [`RV_ADDR_W-1:0] iaddr;
    logic [`RV_ADDR_W-1:0] daddr;
    logic [`RV_XLEN-1:0]   ddata_w;
    logic                  mem_write;
    logic                  mem_read;
    logic                  reg_write_enable;
    logic [4:0]            write_register;
    logic [`RV_XLEN-1:0]   reg_write_data;

    logic [31:0] imem [mem_words];
    logic [31:0] dmem [mem_words];
    logic [31:0] ref_mem [mem_words];
    logic [31:0] ref_regs [32];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_val [$];
    logic [31:0] written_mask;
    int          prog_len;

    rv_core u_rv_core (
        .CLK              (CLK),
        .RESET_N          (RESET_N),
        .idata            (idata),
        .ddata_r          (ddata_r),
        .iaddr            (iaddr),
        .daddr            (daddr),
        .ddata_w          (ddata_w),
        .mem_write        (mem_write),
        .mem_read         (mem_read),
        .reg_write_enable (reg_write_enable),
        .write_register   (write_register),
        .reg_write_data   (reg_write_data)
    );

    always #20 CLK = ~CLK;

    // Both memories read combinationally. A data read returns zero unless the core asks for it.
    assign idata   = imem[iaddr];
    assign ddata_r = mem_read ? dmem[daddr] : '0;

    always @(posedge CLK) begin
        if (mem_write) begin
            dmem[daddr] <= ddata_w;
        end
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_with_error($sformatf("mismatch at %0t: %s is %h, expected %h",
                                      $time, what, got, expected));
        end
    endtask

    // Every register write at the writeback ports must be the next one in program order.
    always @(negedge CLK) begin
        if (RESET_N && reg_write_enable) begin
            if (exp_rd.size() == 0) begin
                stop_with_error($sformatf("unexpected write to x%0d at %0t, program has none left",
                                          write_register, $time));
            end else begin
                check_value("write register", {27'b0, write_register}, exp_rd.pop_front());
                check_value("write data", reg_write_data, exp_val.pop_front());
                written_mask[write_register] = 1'b1;
            end
        end
    end

    function automatic logic [31:0] rtype_word(input int f3, input int sub, input int rd,
                                               input int rs1, input int rs2);
        return {1'b0, sub[0], 5'b0, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_word(input int f3, input int rs1, input int rs2,
                                                input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] lui_word(input int rd, input int upper);
        return {upper[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] reg_op(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b111:  return a & b;
            3'b110:  return a | b;
            3'b100:  return a ^ b;
            default: return {31'b0, $signed(a) < $signed(b)};
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic record_write(input logic [4:0] rd, input logic [31:0] val);
        exp_rd.push_back({27'b0, rd});
        exp_val.push_back(val);
        if (rd != 5'd0) begin
            ref_regs[rd] = val;
        end
    endtask

    // Executes the program in order; a zero word marks its end.
    task automatic run_reference();
        logic [31:0]           ins;
        logic [31:0]           a;
        logic [31:0]           b;
        logic [31:0]           addr;
        logic [12:0]           off;
        logic [`RV_ADDR_W+1:0] pc;
        int                    steps;
        pc    = '0;
        steps = 0;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        while (imem[pc[`RV_ADDR_W+1:2]] != '0 && steps < 1000) begin
            ins = imem[pc[`RV_ADDR_W+1:2]];
            a   = ref_regs[ins[19:15]];
            b   = ref_regs[ins[24:20]];
            off = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            pc  = pc + 12'd4;
            steps++;
            case (ins[6:0])
                7'b0110011: record_write(ins[11:7], reg_op(ins[14:12], ins[30], a, b));
                7'b0010011: record_write(ins[11:7], a + {{20{ins[31]}}, ins[31:20]});
                7'b0110111: record_write(ins[11:7], {ins[31:12], 12'b0});
                7'b0000011: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    record_write(ins[11:7], ref_mem[addr[`RV_ADDR_W+1:2]]);
                end
                7'b0100011: begin
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    ref_mem[addr[`RV_ADDR_W+1:2]] = b;
                end
                7'b1100011: begin
                    if ((a == b) ^ ins[12]) begin
                        pc = pc - 12'd4 + off[11:0];
                    end
                end
                default: stop_with_error("reference model met an unsupported instruction");
            endcase
        end
    endtask

    // Puts the core in reset and gives both memories a fresh image.
    task automatic begin_test();
        @(posedge CLK);
        RESET_N <= 1'b0;
        prog_len     = 0;
        written_mask = '0;
        exp_rd.delete();
        exp_val.delete();
        for (int a = 0; a < mem_words; a++) begin
            imem[a]    = '0;
            ref_mem[a] = 32'h5A3C_0000 ^ (32'(a) * 32'h0001_0101);
            dmem[a]   <= 32'h5A3C_0000 ^ (32'(a) * 32'h0001_0101);
        end
    endtask

    // Nothing may reach the memory stage before cycle 3 or writeback before cycle 4.
    task automatic check_quiet_start();
        for (int i = 0; i < 4; i++) begin
            @(negedge CLK);
            check_value("reg_write_enable after reset", {31'b0, reg_write_enable}, '0);
            if (i < 3) begin
                check_value("mem_read after reset", {31'b0, mem_read}, '0);
                check_value("mem_write after reset", {31'b0, mem_write}, '0);
            end
        end
    endtask

    task automatic run_program(input string name);
        int cycles;
        int writes;
        run_reference();
        writes = exp_rd.size();
        repeat (5) @(posedge CLK);
        RESET_N <= 1'b1;
        check_quiet_start();
        cycles = 0;
        while (exp_rd.size() != 0) begin
            if (cycles == 400) begin
                stop_with_error($sformatf("%s: timed out waiting for register writes", name));
            end
            @(posedge CLK);
            cycles++;
        end
        repeat (6) @(posedge CLK); // Lets trailing stores finish.
        for (int a = 0; a < mem_words; a++) begin
            check_value($sformatf("%s data word %0d", name, a), dmem[a], ref_mem[a]);
        end
        $display("%s: %0d register writes checked", name, writes);
    endtask

    task automatic chain_test();
        begin_test();
        emit(addi(1, 0, 5));
        emit(addi(2, 1, -3));
        emit(rtype_word(0, 0, 3, 2, 1));
        emit(rtype_word(0, 1, 4, 3, 1));
        emit(rtype_word(7, 0, 5, 4, 3));
        emit(rtype_word(6, 0, 6, 5, 1));
        emit(rtype_word(4, 0, 7, 6, 4));
        emit(rtype_word(0, 1, 8, 0, 7));   // Negative result feeds the SLT.
        emit(rtype_word(2, 0, 9, 8, 0));
        emit(lui_word(10, 'hABCDE));
        emit(rtype_word(0, 0, 11, 10, 9));
        emit(addi(11, 11, 'h7FF));
        run_program("dependency chain");
    endtask

    task automatic load_store_test();
        begin_test();
        emit(addi(1, 0, 'h40));
        emit(lui_word(2, 'h12345));
        emit(addi(2, 2, 'h678));
        emit(sw(2, 1, 8));
        emit(lw(3, 1, 8));
        emit(rtype_word(0, 0, 4, 3, 1));   // Uses the load at once.
        emit(lw(5, 1, 8));
        emit(sw(5, 1, 12));
        emit(lw(6, 0, 'h7FC));
        emit(rtype_word(0, 1, 7, 6, 5));
        run_program("store and load");
    endtask

    task automatic branch_test();
        begin_test();
        emit(addi(1, 0, 7));
        emit(addi(2, 0, 7));
        emit(branch_word(0, 1, 2, 12));    // BEQ taken.
        emit(addi(3, 0, 1));
        emit(addi(4, 0, 2));
        emit(addi(5, 0, 3));
        emit(branch_word(1, 1, 2, 12));
        emit(addi(6, 0, 4));
        emit(branch_word(0, 1, 5, 12));
        emit(addi(7, 0, 5));
        emit(branch_word(1, 1, 5, 12));    // BNE taken.
        emit(addi(8, 0, 6));
        emit(addi(9, 0, 7));
        emit(addi(10, 1, 8));
        run_program("branches");
        check_value("writes after taken branches", written_mask & 32'h0000_0318, '0);
        check_value("writes at branch targets", written_mask & 32'h0000_0420, 32'h0000_0420);
    endtask

    task automatic random_program_test();
        int kind;
        int rd;
        int rs1;
        int rs2;
        begin_test();
        for (int n = 0; n < 40; n++) begin
            kind = $urandom_range(7, 0);
            rd   = $urandom_range(7, 0);
            rs1  = $urandom_range(7, 0);
            rs2  = $urandom_range(7, 0);
            case (kind)
                0: emit(rtype_word(0, 0, rd, rs1, rs2));
                1: emit(rtype_word(0, 1, rd, rs1, rs2));
                2: emit(rtype_word(7, 0, rd, rs1, rs2));
                3: emit(rtype_word(6, 0, rd, rs1, rs2));
                4: emit(rtype_word(4, 0, rd, rs1, rs2));
                5: emit(rtype_word(2, 0, rd, rs1, rs2));
                6: emit(addi(rd, rs1, $urandom_range(4095, 0)));
                default: emit(lui_word(rd, $urandom));
            endcase
        end
        run_program("random sequence");
    endtask

    initial begin
        void'($urandom(77928));
        CLK     = 1'b0;
        RESET_N = 1'b0;
        for (int a = 0; a < mem_words; a++) begin
            imem[a]  = '0;
            dmem[a] <= '0;
        end
        chain_test();
        load_store_test();
        branch_test();
        random_program_test();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/rv_core_pkg.sv
source/decode_control.sv
source/register_file.sv
source/alu.sv
source/hazard_unit.sv
source/rv_core.sv
verif/tb_rv_core.sv

// File: Makefile
SIM := obj_dir/Vtb_rv_core

# Rebuilt only when a source, header or the file list changes.
$(SIM): sim.f $(wildcard source/*.sv source/*.svh verif/*.sv)
	verilator --binary --timing --top-module tb_rv_core -f sim.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

.PHONY: run clean
